/* btn_input_top.f */
hw/btn_pkg.sv
hw/input_sync.sv
hw/button_debouncer.sv
hw/edge_event_unit.sv
hw/apb_btn_regs.sv
hw/btn_input_top.sv
verif/btn_input_tb.sv

/* verif/btn_input_tb.sv */
//----------------------------
// Self-checking testbench for the button peripheral, driven over APB
// Rows of a stimulus table are applied in order and checked against expected values
//----------------------------

`timescale 1ns/1ps

module btn_input_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int TEST_DIV    = 7;
  localparam int TICK_CYCLES = TEST_DIV + 1;
  // Longest glitch stays below PULSE_COUNT_MAX-1 ticks
  localparam int GLITCH_MAX  = (btn_pkg::PULSE_COUNT_MAX - 1) * TICK_CYCLES - 1;
  localparam int APB_TIMEOUT = 16;
  localparam int LEVEL_POLLS = 64;
  localparam int NUM_ROWS    = 11;

  logic                 clk;
  logic                 rst;
  btn_pkg::btn_word_t   btn_raw;
  btn_pkg::apb_addr_t   paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  btn_pkg::apb_data_t   pwdata;
  btn_pkg::apb_data_t   prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 irq;

  int error_count;
  int timeout_count;

  //----------------------------
  // Stimulus table
  //----------------------------

  typedef struct packed {
    btn_pkg::btn_word_t irq_en;
    btn_pkg::btn_word_t pattern;
    logic [7:0]         hold_ticks;
    logic               glitch;
    btn_pkg::btn_word_t clr_press;
    btn_pkg::btn_word_t clr_release;
    btn_pkg::btn_word_t exp_level;
    btn_pkg::btn_word_t exp_press;
    btn_pkg::btn_word_t exp_release;
    logic               exp_irq;
  } row_t;

  row_t rows [NUM_ROWS];

  btn_input_top i_btn_input_top (
    .clk     (clk),
    .rst     (rst),
    .btn_raw (btn_raw),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Hard stop in case a wait loop itself misbehaves
  initial begin
    #2_000_000;
    $display("simulation watchdog expired before the test finished");
    $display("sim failed");
    $finish;
  end

  //----------------------------
  // Compare tasks
  //----------------------------

  task automatic check_word(input string what, input btn_pkg::btn_word_t got,
                            input btn_pkg::btn_word_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s read %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_div(input string what, input btn_pkg::sample_div_t got,
                           input btn_pkg::sample_div_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s read %0d, expected %0d", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_irq(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s irq is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_resp(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s pslverr is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  //----------------------------
  // APB tasks
  //----------------------------

  // SETUP then ACCESS, sampled 1 ns before the closing edge
  task automatic apb_transfer(input btn_pkg::apb_addr_t addr, input logic write,
                              input btn_pkg::apb_data_t wdata,
                              output btn_pkg::apb_data_t rdata);
    int wait_cnt;
    @(posedge clk);
    #1;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #(CLK_PERIOD - 2);
    wait_cnt = 0;
    while (!pready && wait_cnt < APB_TIMEOUT) begin
      #(CLK_PERIOD);
      wait_cnt++;
    end
    if (!pready) begin
      $display("timeout waiting for pready at %0t ns", $time);
      timeout_count++;
    end
    // Slave never signals an error response
    check_resp($sformatf("APB access to 0x%h", addr), pslverr, 1'b0);
    rdata = prdata;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input btn_pkg::apb_addr_t addr, input btn_pkg::apb_data_t data);
    btn_pkg::apb_data_t unused;
    apb_transfer(addr, 1'b1, data, unused);
  endtask

  task automatic apb_read(input btn_pkg::apb_addr_t addr, output btn_pkg::apb_data_t data);
    apb_transfer(addr, 1'b0, '0, data);
  endtask

  //----------------------------
  // Stimulus helpers
  //----------------------------

  // Short random pulses on the masked lines, low between them
  task automatic drive_glitches(input btn_pkg::btn_word_t mask, input int budget);
    int elapsed;
    int high_len;
    int low_len;
    elapsed = 0;
    while (elapsed < budget) begin
      high_len = 1 + ($urandom % GLITCH_MAX);
      low_len  = 1 + ($urandom % 4);
      btn_raw  = mask & btn_pkg::btn_word_t'($urandom);
      repeat (high_len) @(posedge clk);
      #1;
      btn_raw = '0;
      repeat (low_len) @(posedge clk);
      #1;
      elapsed += high_len + low_len;
    end
  endtask

  // Poll LEVEL until it matches
  task automatic wait_level(input int r, input btn_pkg::btn_word_t exp);
    btn_pkg::apb_data_t rdata;
    int polls;
    polls = 0;
    apb_read(btn_pkg::ADDR_LEVEL, rdata);
    while (rdata[btn_pkg::BTN_WIDTH-1:0] !== exp && polls < LEVEL_POLLS) begin
      apb_read(btn_pkg::ADDR_LEVEL, rdata);
      polls++;
    end
    if (rdata[btn_pkg::BTN_WIDTH-1:0] !== exp) begin
      $display("timeout waiting for LEVEL %b in row %0d at %0t ns", exp, r, $time);
      timeout_count++;
    end
  endtask

  task automatic apply_row(input int r);
    btn_pkg::apb_data_t rdata;
    apb_write(btn_pkg::ADDR_IRQ_EN, 32'(rows[r].irq_en));
    if (rows[r].glitch) begin
      drive_glitches(rows[r].pattern, rows[r].hold_ticks * TICK_CYCLES);
    end else begin
      btn_raw = rows[r].pattern;
      repeat (rows[r].hold_ticks * TICK_CYCLES) @(posedge clk);
      #1;
    end
    wait_level(r, rows[r].exp_level);
    if (rows[r].clr_press != '0) begin
      apb_write(btn_pkg::ADDR_PRESS, 32'(rows[r].clr_press));
    end
    if (rows[r].clr_release != '0) begin
      apb_write(btn_pkg::ADDR_RELEASE, 32'(rows[r].clr_release));
    end
    // irq trails a flag change by one cycle
    repeat (2) @(posedge clk);
    #1;
    check_irq($sformatf("row %0d", r), irq, rows[r].exp_irq);
    apb_read(btn_pkg::ADDR_PRESS, rdata);
    check_word($sformatf("row %0d PRESS", r), rdata[btn_pkg::BTN_WIDTH-1:0], rows[r].exp_press);
    apb_read(btn_pkg::ADDR_RELEASE, rdata);
    check_word($sformatf("row %0d RELEASE", r), rdata[btn_pkg::BTN_WIDTH-1:0],
               rows[r].exp_release);
    apb_read(btn_pkg::ADDR_LEVEL, rdata);
    check_word($sformatf("row %0d LEVEL", r), rdata[btn_pkg::BTN_WIDTH-1:0], rows[r].exp_level);
  endtask

  //----------------------------
  // Main sequence
  //----------------------------

  initial begin
    btn_pkg::apb_data_t rdata;
    error_count   = 0;
    timeout_count = 0;
    void'($urandom(47));
    rst     = 1'b1;
    btn_raw = '0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;

    // irq_en, pattern, hold, glitch, clr_p, clr_r, level, press, release, irq
    rows[0]  = '{4'hF, 4'b1111, 8'd12, 1'b1, 4'h0, 4'h0, 4'b0000, 4'b0000, 4'b0000, 1'b0};
    rows[1]  = '{4'hF, 4'b0101, 8'd8,  1'b0, 4'h0, 4'h0, 4'b0101, 4'b0101, 4'b0000, 1'b1};
    rows[2]  = '{4'hF, 4'b0100, 8'd8,  1'b0, 4'h0, 4'h0, 4'b0100, 4'b0101, 4'b0001, 1'b1};
    rows[3]  = '{4'hF, 4'b0100, 8'd2,  1'b0, 4'h1, 4'h0, 4'b0100, 4'b0100, 4'b0001, 1'b1};
    rows[4]  = '{4'hF, 4'b0100, 8'd2,  1'b0, 4'h0, 4'h1, 4'b0100, 4'b0100, 4'b0000, 1'b1};
    rows[5]  = '{4'hF, 4'b0000, 8'd2,  1'b0, 4'h4, 4'h0, 4'b0000, 4'b0000, 4'b0100, 1'b1};
    rows[6]  = '{4'hF, 4'b0000, 8'd2,  1'b0, 4'h0, 4'h4, 4'b0000, 4'b0000, 4'b0000, 1'b0};
    rows[7]  = '{4'hF, 4'b1010, 8'd10, 1'b1, 4'h0, 4'h0, 4'b0000, 4'b0000, 4'b0000, 1'b0};
    // Mask off, then on
    rows[8]  = '{4'h0, 4'b1000, 8'd8,  1'b0, 4'h0, 4'h0, 4'b1000, 4'b1000, 4'b0000, 1'b0};
    rows[9]  = '{4'hF, 4'b1000, 8'd2,  1'b0, 4'h0, 4'h0, 4'b1000, 4'b1000, 4'b0000, 1'b1};
    rows[10] = '{4'hF, 4'b0000, 8'd2,  1'b0, 4'h8, 4'h8, 4'b0000, 4'b0000, 4'b0000, 1'b0};

    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset values
    apb_read(btn_pkg::ADDR_LEVEL, rdata);
    check_word("reset LEVEL", rdata[btn_pkg::BTN_WIDTH-1:0], '0);
    apb_read(btn_pkg::ADDR_PRESS, rdata);
    check_word("reset PRESS", rdata[btn_pkg::BTN_WIDTH-1:0], '0);
    apb_read(btn_pkg::ADDR_RELEASE, rdata);
    check_word("reset RELEASE", rdata[btn_pkg::BTN_WIDTH-1:0], '0);
    apb_read(btn_pkg::ADDR_IRQ_EN, rdata);
    check_word("reset IRQ_EN", rdata[btn_pkg::BTN_WIDTH-1:0], '0);
    apb_read(btn_pkg::ADDR_SAMPLE_DIV, rdata);
    check_div("reset SAMPLE_DIV", rdata[btn_pkg::SAMPLE_DIV_W-1:0], btn_pkg::SAMPLE_DIV_RST);
    check_irq("reset", irq, 1'b0);

    // Sample period and unmapped offsets
    apb_write(btn_pkg::ADDR_SAMPLE_DIV, 32'(TEST_DIV));
    apb_read(btn_pkg::ADDR_SAMPLE_DIV, rdata);
    check_div("SAMPLE_DIV readback", rdata[btn_pkg::SAMPLE_DIV_W-1:0], TEST_DIV);
    apb_write(8'h14, 32'hFFFF_FFFF);
    apb_write(8'h3C, 32'hFFFF_FFFF);
    apb_write(btn_pkg::ADDR_LEVEL, 32'hF);
    apb_read(8'h14, rdata);
    check_div("unmapped 0x14", rdata[btn_pkg::SAMPLE_DIV_W-1:0], '0);
    apb_read(8'h3C, rdata);
    check_div("unmapped 0x3C", rdata[btn_pkg::SAMPLE_DIV_W-1:0], '0);
    apb_read(btn_pkg::ADDR_IRQ_EN, rdata);
    check_word("IRQ_EN after unmapped writes", rdata[btn_pkg::BTN_WIDTH-1:0], '0);
    apb_read(btn_pkg::ADDR_LEVEL, rdata);
    check_word("LEVEL after write", rdata[btn_pkg::BTN_WIDTH-1:0], '0);
    apb_read(btn_pkg::ADDR_SAMPLE_DIV, rdata);
    check_div("SAMPLE_DIV after unmapped writes", rdata[btn_pkg::SAMPLE_DIV_W-1:0], TEST_DIV);

    // New period is picked up at the next wrap of the old one
    repeat (int'(btn_pkg::SAMPLE_DIV_RST) + 2) @(posedge clk);
    #1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
    end

    $display("checks done: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* hw/btn_input_top.sv */
//----------------------------
// Button input peripheral top with synchronizer, debouncer, events and APB regs
//----------------------------

`timescale 1ns/1ps

module btn_input_top (
  input  logic               clk,
  input  logic               rst,
  input  btn_pkg::btn_word_t btn_raw,
  // APB slave
  input  btn_pkg::apb_addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  btn_pkg::apb_data_t pwdata,
  output btn_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  // Interrupt to the core
  output logic               irq
);

  //----------------------------
  // Internal wires
  //----------------------------

  btn_pkg::btn_word_t   btn_sync;
  btn_pkg::btn_word_t   btn_level;
  btn_pkg::sample_div_t sample_div;
  btn_pkg::btn_word_t   clear_press;
  btn_pkg::btn_word_t   clear_release;
  btn_pkg::btn_word_t   irq_en;
  btn_pkg::btn_word_t   press_flags;
  btn_pkg::btn_word_t   release_flags;

  //----------------------------
  // Input path
  //----------------------------

  input_sync i_input_sync (
    .clk      (clk),
    .rst      (rst),
    .btn_raw  (btn_raw),
    .btn_sync (btn_sync)
  );

  button_debouncer #(
    .WIDTH (btn_pkg::BTN_WIDTH)
  ) i_button_debouncer (
    .clk        (clk),
    .rst        (rst),
    .btn_sync   (btn_sync),
    .sample_div (sample_div),
    .btn_level  (btn_level)
  );

  //----------------------------
  // Events and registers
  //----------------------------

  edge_event_unit i_edge_event_unit (
    .clk           (clk),
    .rst           (rst),
    .btn_level     (btn_level),
    .clear_press   (clear_press),
    .clear_release (clear_release),
    .irq_en        (irq_en),
    .press_flags   (press_flags),
    .release_flags (release_flags),
    .irq           (irq)
  );

  apb_btn_regs i_apb_btn_regs (
    .clk           (clk),
    .rst           (rst),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .btn_level     (btn_level),
    .press_flags   (press_flags),
    .release_flags (release_flags),
    .clear_press   (clear_press),
    .clear_release (clear_release),
    .irq_en        (irq_en),
    .sample_div    (sample_div)
  );

endmodule

/* hw/apb_btn_regs.sv */
//----------------------------
// APB register file for levels, event flags, interrupt mask and sample period
// Zero wait states and no error responses
//----------------------------

`timescale 1ns/1ps

module apb_btn_regs (
  input  logic                 clk,
  input  logic                 rst,
  // APB slave
  input  btn_pkg::apb_addr_t   paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  btn_pkg::apb_data_t   pwdata,
  output btn_pkg::apb_data_t   prdata,
  output logic                 pready,
  output logic                 pslverr,
  // Status from the datapath
  input  btn_pkg::btn_word_t   btn_level,
  input  btn_pkg::btn_word_t   press_flags,
  input  btn_pkg::btn_word_t   release_flags,
  // Control to the datapath
  output btn_pkg::btn_word_t   clear_press,
  output btn_pkg::btn_word_t   clear_release,
  output btn_pkg::btn_word_t   irq_en,
  output btn_pkg::sample_div_t sample_div
);

  //----------------------------
  // Access decode
  //----------------------------

  logic access;
  logic wr_en;
  logic rd_en;

  // Address hits
  logic hit_level;
  logic hit_press;
  logic hit_release;
  logic hit_irq_en;
  logic hit_div;

  // ACCESS phase of a transfer
  assign access = psel & penable;
  assign wr_en  = access & pwrite;
  assign rd_en  = access & ~pwrite;

  assign hit_level   = (paddr == btn_pkg::ADDR_LEVEL);
  assign hit_press   = (paddr == btn_pkg::ADDR_PRESS);
  assign hit_release = (paddr == btn_pkg::ADDR_RELEASE);
  assign hit_irq_en  = (paddr == btn_pkg::ADDR_IRQ_EN);
  assign hit_div     = (paddr == btn_pkg::ADDR_SAMPLE_DIV);

  // Never stalls, never errors
  assign pready  = 1'b1;
  assign pslverr = 1'b0;

  //----------------------------
  // Control registers
  //----------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      irq_en     <= '0;
      sample_div <= btn_pkg::SAMPLE_DIV_RST;
    end else if (wr_en) begin
      if (hit_irq_en) begin
        irq_en <= pwdata[btn_pkg::BTN_WIDTH-1:0];
      end
      if (hit_div) begin
        sample_div <= pwdata[btn_pkg::SAMPLE_DIV_W-1:0];
      end
    end
  end

  //----------------------------
  // Write-one-to-clear pulses
  //----------------------------

  // Live only in ACCESS so the flags clear on the closing edge
  assign clear_press   = (wr_en && hit_press) ?
                         pwdata[btn_pkg::BTN_WIDTH-1:0] : '0;
  assign clear_release = (wr_en && hit_release) ?
                         pwdata[btn_pkg::BTN_WIDTH-1:0] : '0;

  //----------------------------
  // Read mux
  //----------------------------

  always_comb begin
    // Unmapped offsets and idle bus read zero
    prdata = '0;
    if (rd_en) begin
      if (hit_level) begin
        prdata[btn_pkg::BTN_WIDTH-1:0] = btn_level;
      end
      if (hit_press) begin
        prdata[btn_pkg::BTN_WIDTH-1:0] = press_flags;
      end
      if (hit_release) begin
        prdata[btn_pkg::BTN_WIDTH-1:0] = release_flags;
      end
      if (hit_irq_en) begin
        prdata[btn_pkg::BTN_WIDTH-1:0] = irq_en;
      end
      if (hit_div) begin
        prdata[btn_pkg::SAMPLE_DIV_W-1:0] = sample_div;
      end
    end
  end

  //----------------------------
  // Protocol checks
  //----------------------------

  // ACCESS only inside a selected transfer
  a_enable_needs_sel: assert property (
    @(posedge clk) disable iff (rst)
    penable |-> psel
  ) else $error("APB penable high without psel");

  // SETUP is always followed by ACCESS
  a_setup_then_access: assert property (
    @(posedge clk) disable iff (rst)
    (psel && !penable) |=> (psel && penable)
  ) else $error("APB SETUP not followed by ACCESS");

endmodule

/* hw/edge_event_unit.sv */
//----------------------------
// Edge detector with sticky press/release flags and a masked interrupt
//----------------------------

`timescale 1ns/1ps

module edge_event_unit (
  input  logic               clk,
  input  logic               rst,
  input  btn_pkg::btn_word_t btn_level,
  input  btn_pkg::btn_word_t clear_press,
  input  btn_pkg::btn_word_t clear_release,
  input  btn_pkg::btn_word_t irq_en,
  output btn_pkg::btn_word_t press_flags,
  output btn_pkg::btn_word_t release_flags,
  output logic               irq
);

  //----------------------------
  // Edge detection
  //----------------------------

  // Previous debounced level
  btn_pkg::btn_word_t level_q;
  btn_pkg::btn_word_t rise_edge;
  btn_pkg::btn_word_t fall_edge;

  assign rise_edge = btn_level & ~level_q;
  assign fall_edge = ~btn_level & level_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      level_q <= '0;
    end else begin
      level_q <= btn_level;
    end
  end

  //----------------------------
  // Sticky flags and interrupt
  //----------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      press_flags   <= '0;
      release_flags <= '0;
      irq           <= 1'b0;
    end else begin
      // Set beats a clear in the same cycle
      press_flags   <= (press_flags & ~clear_press) | rise_edge;
      release_flags <= (release_flags & ~clear_release) | fall_edge;
      // Registered OR of masked flags
      irq           <= |((press_flags | release_flags) & irq_en);
    end
  end

  //----------------------------
  // Checks
  //----------------------------

  // New press flag only right after a rising level
  a_press_cause: assert property (
    @(posedge clk) disable iff (rst)
    (press_flags & ~$past(press_flags) & ~$past(rise_edge)) == '0
  ) else $error("press flag set without a rising level edge");

  // Same for release and falling level
  a_release_cause: assert property (
    @(posedge clk) disable iff (rst)
    (release_flags & ~$past(release_flags) & ~$past(fall_edge)) == '0
  ) else $error("release flag set without a falling level edge");

endmodule

/* hw/button_debouncer.sv */
//----------------------------
// Debouncer with one shared sample tick counter and a saturating counter per bit
// A level bit rises after PULSE_COUNT_MAX consecutive high samples
//----------------------------

`timescale 1ns/1ps

module button_debouncer #(
  parameter int WIDTH = btn_pkg::BTN_WIDTH
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [WIDTH-1:0]    btn_sync,
  input  btn_pkg::sample_div_t sample_div,
  output logic [WIDTH-1:0]    btn_level
);

  //----------------------------
  // Signals
  //----------------------------

  // Shared wrapping counter
  btn_pkg::sample_div_t wrap_cnt;
  // Period in use for the current interval
  btn_pkg::sample_div_t div_q;
  logic                 tick;

  // Per-bit saturating counters
  logic [btn_pkg::SAT_CNT_W-1:0] sat_cnt [WIDTH];
  logic [WIDTH-1:0]              sat_full;

  //----------------------------
  // Sample tick generator
  //----------------------------

  // Tick on the last count of the period
  assign tick = (wrap_cnt == div_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      wrap_cnt <= '0;
      div_q    <= btn_pkg::SAMPLE_DIV_RST;
    end else if (tick) begin
      wrap_cnt <= '0;
      // New period only picked up at wrap
      div_q    <= sample_div;
    end else begin
      wrap_cnt <= wrap_cnt + 1'b1;
    end
  end

  //----------------------------
  // Saturating counters
  //----------------------------

  for (genvar i = 0; i < WIDTH; i++) begin : g_bit

    // Saturated means debounced high
    assign sat_full[i] = (sat_cnt[i] == btn_pkg::SAT_CNT_W'(btn_pkg::PULSE_COUNT_MAX));

    always_ff @(posedge clk) begin
      if (rst || !btn_sync[i]) begin
        // Any low sample restarts the count
        sat_cnt[i] <= '0;
      end else if (tick && !sat_full[i]) begin
        sat_cnt[i] <= sat_cnt[i] + 1'b1;
      end
    end

    // Level straight from the counter state
    assign btn_level[i] = sat_full[i];

    // Hold at max must never be overrun
    a_sat_bound: assert property (
      @(posedge clk) disable iff (rst)
      sat_cnt[i] <= btn_pkg::SAT_CNT_W'(btn_pkg::PULSE_COUNT_MAX)
    ) else $error("debouncer counter %0d above PULSE_COUNT_MAX", i);

  end

endmodule

/* hw/input_sync.sv */
//----------------------------
// Two-flop synchronizer for the asynchronous button lines
//----------------------------

`timescale 1ns/1ps

module input_sync (
  input  logic              clk,
  input  logic              rst,
  input  btn_pkg::btn_word_t btn_raw,
  output btn_pkg::btn_word_t btn_sync
);

  // First stage may go metastable
  btn_pkg::btn_word_t sync_q1;

  //----------------------------
  // Synchronizer chain
  //----------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q1  <= '0;
      btn_sync <= '0;
    end else begin
      // Sample raw lines
      sync_q1  <= btn_raw;
      // Second stage settles the value
      btn_sync <= sync_q1;
    end
  end

  // Two cycles from raw line to synchronized output
  // Debouncer downstream only sees btn_sync
  // Each bit is an independent chain

endmodule

/* hw/btn_pkg.sv */
//----------------------------
// Shared widths, APB register offsets and word types for the button peripheral
// Referenced by scoped names from every RTL block
//----------------------------

package btn_pkg;

  //----------------------------
  // Widths
  //----------------------------

  // One bit per push-button line
  localparam int BTN_WIDTH = 4;

  // Sample period register width
  localparam int SAMPLE_DIV_W = 16;

  // Consecutive high samples needed for a press
  localparam int PULSE_COUNT_MAX = 4;

  // Counter must be able to hold PULSE_COUNT_MAX itself
  localparam int SAT_CNT_W = $clog2(PULSE_COUNT_MAX + 1);

  //----------------------------
  // Reset values
  //----------------------------

  // 2500 clocks per sample tick
  localparam logic [SAMPLE_DIV_W-1:0] SAMPLE_DIV_RST = 16'd2499;

  //----------------------------
  // APB byte offsets
  //----------------------------

  localparam logic [7:0] ADDR_LEVEL      = 8'h00;
  localparam logic [7:0] ADDR_PRESS      = 8'h04;
  localparam logic [7:0] ADDR_RELEASE    = 8'h08;
  localparam logic [7:0] ADDR_IRQ_EN     = 8'h0C;
  localparam logic [7:0] ADDR_SAMPLE_DIV = 8'h10;

  //----------------------------
  // Word types
  //----------------------------

  typedef logic [BTN_WIDTH-1:0]    btn_word_t;
  typedef logic [SAMPLE_DIV_W-1:0] sample_div_t;
  typedef logic [7:0]              apb_addr_t;
  typedef logic [31:0]             apb_data_t;

endpackage
